//--- sys_pkg.sv
package sys_pkg;

   localparam logic [7:0]  CLK_PER_US  = 8'd50;    // 50 MHz system clock
   localparam logic [15:0] CLK_PER_BIT = 16'd434;  // 115200 baud
   localparam logic [7:0]  RST_HOLD    = 8'd16;    // reset stretch after last cause

   typedef logic [7:0] seg_code_t;                 // dp at bit 7, all active low

   // gfedcba patterns inverted, decimal point dark
   localparam seg_code_t SEG_TABLE [16] = '{
      8'hC0,                                       // 0
      8'hF9,                                       // 1
      8'hA4,                                       // 2
      8'hB0,                                       // 3
      8'h99,                                       // 4
      8'h92,                                       // 5
      8'h82,                                       // 6
      8'hF8,                                       // 7
      8'h80,                                       // 8
      8'h90,                                       // 9
      8'h88,                                       // a
      8'h83,                                       // b
      8'hC6,                                       // c
      8'hA1,                                       // d
      8'h86,                                       // e
      8'h8E                                        // f
   };

endpackage

//--- bus_pkg.sv
package bus_pkg;

   typedef logic [3:0]  reg_adr_t;                 // register index
   typedef logic [15:0] reg_dat_t;                 // register word
   typedef logic [7:0]  byte_t;                    // serial byte

   localparam logic [3:0] FRAME_MARK = 4'hA;       // header upper nibble

   // master to slave, held until ack
   typedef struct packed {
      logic     req;                               // request level
      logic     we;                                // write enable
      reg_adr_t adr;                               // register address
      reg_dat_t dat;                               // write data
   } bus_req_t;

   // slave to master
   typedef struct packed {
      logic     ack;                               // one-cycle acknowledge
      reg_dat_t dat;                               // read data, valid with ack
   } bus_rsp_t;

endpackage

//--- sys_ctl.sv
module sys_ctl
(
   input  logic sys_clk_p,                         // system clock
   input  logic arst_n,                            // async reset, active low
   input  logic sys_plock,                         // pll locked
   input  logic ext_reset,                         // reset button
   output logic sys_rst,                           // stretched system reset
   output logic sys_us                             // microsecond strobe
);
   import sys_pkg::*;

   logic [1:0] plock_sync;                         // lock synchronizer
   logic [1:0] ext_sync;                           // button synchronizer
   logic       rst_cause;                          // any reset reason present
   logic [7:0] hold_cnt;                           // stretch counter
   logic [7:0] us_cnt;                             // microsecond divider

   assign rst_cause = ~plock_sync[1] | ext_sync[1];

   always_ff @(posedge sys_clk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         plock_sync <= 2'b00;
         ext_sync   <= 2'b00;
         hold_cnt   <= RST_HOLD;
         sys_rst    <= 1'b1;                       // asserted at once
      end
      else
      begin
         plock_sync <= {plock_sync[0], sys_plock};
         ext_sync   <= {ext_sync[0], ext_reset};
         if (rst_cause)
            hold_cnt <= RST_HOLD;                  // restart the hold
         else if (hold_cnt != 8'd0)
            hold_cnt <= hold_cnt - 8'd1;
         sys_rst <= rst_cause | (hold_cnt != 8'd0);
      end
   end

   // divider restarts with every reset release
   always_ff @(posedge sys_clk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         us_cnt <= 8'd0;
         sys_us <= 1'b0;
      end
      else if (sys_rst || rst_cause)               // cause also covers the rising edge
      begin
         us_cnt <= 8'd0;
         sys_us <= 1'b0;                           // quiet in reset
      end
      else if (us_cnt == CLK_PER_US - 8'd1)
      begin
         us_cnt <= 8'd0;
         sys_us <= 1'b1;
      end
      else
      begin
         us_cnt <= us_cnt + 8'd1;
         sys_us <= 1'b0;
      end
   end

endmodule

//--- uart_rx.sv
module uart_rx
(
   input  logic           sys_clk_p,               // system clock
   input  logic           arst_n,                  // async reset, active low
   input  logic           sys_rst,                 // system reset
   input  logic           uart_rxd,                // serial input
   output logic           byte_stb,                // byte received
   output bus_pkg::byte_t rx_byte,                 // received byte
   output logic           frame_err                // stop bit was 0
);
   import sys_pkg::*;
   import bus_pkg::*;

   typedef enum logic [1:0] {idle, start, data, stop} rx_state_t;

   rx_state_t   state;                             // receiver state
   logic [2:0]  rxd_sync;                          // sync chain plus edge tap
   logic [15:0] bit_cnt;                           // clocks to next sample point
   logic [2:0]  bit_idx;                           // data bit number
   byte_t       rx_shift;                          // lsb first shifter
   logic        sample;                            // sample point reached

   assign sample = (bit_cnt == 16'd0);

   always_ff @(posedge sys_clk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= idle;
         rxd_sync  <= 3'b111;                      // line idles high
         bit_cnt   <= 16'd0;
         bit_idx   <= 3'd0;
         byte_stb  <= 1'b0;
         frame_err <= 1'b0;
      end
      else if (sys_rst)
      begin
         state     <= idle;
         rxd_sync  <= 3'b111;
         bit_cnt   <= 16'd0;
         bit_idx   <= 3'd0;
         byte_stb  <= 1'b0;
         frame_err <= 1'b0;
      end
      else
      begin
         rxd_sync  <= {rxd_sync[1:0], uart_rxd};
         byte_stb  <= 1'b0;                        // strobes last one cycle
         frame_err <= 1'b0;
         if (!sample)
            bit_cnt <= bit_cnt - 16'd1;
         case (state)
            idle:
               if (rxd_sync[2] && !rxd_sync[1])    // falling start edge
               begin
                  bit_cnt <= CLK_PER_BIT >> 1;     // to middle of start bit
                  state   <= start;
               end
            start:
               if (sample)
               begin
                  bit_cnt <= CLK_PER_BIT - 16'd1;
                  bit_idx <= 3'd0;
                  state   <= rxd_sync[1] ? idle : data;  // high means glitch
               end
            data:
               if (sample)
               begin
                  bit_cnt <= CLK_PER_BIT - 16'd1;
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7)
                     state <= stop;
               end
            default:
               if (sample)
               begin
                  byte_stb  <= rxd_sync[1];
                  frame_err <= ~rxd_sync[1];
                  state     <= idle;
               end
         endcase
      end
   end

   // payload path
   always_ff @(posedge sys_clk_p)
   begin
      if (state == data && sample)
         rx_shift <= {rxd_sync[1], rx_shift[7:1]};
      if (state == stop && sample)
         rx_byte <= rx_shift;
   end

endmodule

//--- cmd_loader.sv
module cmd_loader
(
   input  logic              sys_clk_p,            // system clock
   input  logic              arst_n,               // async reset, active low
   input  logic              sys_rst,              // system reset
   input  logic              byte_stb,             // byte from receiver
   input  bus_pkg::byte_t    rx_byte,              // received byte
   input  logic              frame_err,            // bad stop bit
   input  bus_pkg::bus_rsp_t ld_rsp,               // response from arbiter
   output bus_pkg::bus_req_t ld_req                // write request
);
   import bus_pkg::*;

   typedef enum logic [1:0] {wait_hdr, wait_hi, wait_lo, write} ld_state_t;

   ld_state_t state;                               // frame position

   always_ff @(posedge sys_clk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state  <= wait_hdr;
         ld_req <= '0;
      end
      else if (sys_rst)
      begin
         state  <= wait_hdr;
         ld_req <= '0;
      end
      else if (frame_err && state != write)
         state <= wait_hdr;                        // drop partial frame
      else
      begin
         case (state)
            wait_hdr:
               if (byte_stb && rx_byte[7:4] == FRAME_MARK)
               begin
                  ld_req.adr <= rx_byte[3:0];      // low nibble is address
                  state      <= wait_hi;
               end
            wait_hi:
               if (byte_stb)
               begin
                  ld_req.dat[15:8] <= rx_byte;
                  state            <= wait_lo;
               end
            wait_lo:
               if (byte_stb)
               begin
                  ld_req.dat[7:0] <= rx_byte;
                  ld_req.we       <= 1'b1;         // loader only writes
                  ld_req.req      <= 1'b1;
                  state           <= write;
               end
            default:
               if (ld_rsp.ack)
               begin
                  ld_req.req <= 1'b0;              // done, release bus
                  state      <= wait_hdr;
               end
         endcase
      end
   end

endmodule

//--- bus_arb.sv
module bus_arb
(
   input  logic              sys_clk_p,            // system clock
   input  logic              arst_n,               // async reset, active low
   input  logic              sys_rst,              // system reset
   input  bus_pkg::bus_req_t ld_req,               // loader request
   input  bus_pkg::bus_req_t sc_req,               // scanner request
   input  bus_pkg::bus_rsp_t mem_rsp,              // register file response
   output bus_pkg::bus_rsp_t ld_rsp,               // loader response
   output bus_pkg::bus_rsp_t sc_rsp,               // scanner response
   output bus_pkg::bus_req_t mem_req               // granted request
);
   logic busy;                                     // transaction in flight
   logic owner;                                    // 0 loader, 1 scanner
   logic last;                                     // master served last
   logic pick;                                     // winner when idle

   always_comb
   begin
      if (ld_req.req && sc_req.req)
         pick = ~last;                             // tie goes to the other one
      else
         pick = sc_req.req;
   end

   assign mem_req = busy ? (owner ? sc_req : ld_req) : '0;
   assign ld_rsp  = (busy && !owner) ? mem_rsp : '0;   // owner sees ack only
   assign sc_rsp  = (busy && owner) ? mem_rsp : '0;

   always_ff @(posedge sys_clk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         busy  <= 1'b0;
         owner <= 1'b0;
         last  <= 1'b1;                            // loader first
      end
      else if (sys_rst)
      begin
         busy  <= 1'b0;
         owner <= 1'b0;
         last  <= 1'b1;
      end
      else if (!busy)
      begin
         if (ld_req.req || sc_req.req)
         begin
            busy  <= 1'b1;
            owner <= pick;
         end
      end
      else if (mem_rsp.ack)
      begin
         busy <= 1'b0;                             // free after ack
         last <= owner;
      end
   end

endmodule

//--- reg_ram.sv
module reg_ram
(
   input  logic              sys_clk_p,            // system clock
   input  logic              arst_n,               // async reset, active low
   input  logic              sys_rst,              // system reset
   input  bus_pkg::bus_req_t mem_req,              // request from arbiter
   output bus_pkg::bus_rsp_t mem_rsp               // ack and read data
);
   import bus_pkg::*;

   reg_dat_t regs [16];                            // register file
   logic     take;                                 // new request this cycle

   assign take = mem_req.req && !mem_rsp.ack;      // skip request in ack cycle

   always_ff @(posedge sys_clk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         regs    <= '{default: '0};
         mem_rsp <= '0;
      end
      else if (sys_rst)
      begin
         regs    <= '{default: '0};
         mem_rsp <= '0;
      end
      else
      begin
         mem_rsp.ack <= take;                      // one cycle after sampling
         if (take && mem_req.we)
            regs[mem_req.adr] <= mem_req.dat;
         else if (take)
            mem_rsp.dat <= regs[mem_req.adr];
      end
   end

endmodule

//--- disp_scan.sv
module disp_scan
(
   input  logic                sys_clk_p,          // system clock
   input  logic                arst_n,             // async reset, active low
   input  logic                sys_rst,            // system reset
   input  logic                sys_us,             // microsecond strobe
   input  bus_pkg::bus_rsp_t   sc_rsp,             // response from arbiter
   output bus_pkg::bus_req_t   sc_req,             // read request
   output sys_pkg::seg_code_t  seg_hex0,           // digit 0, bits 3:0
   output sys_pkg::seg_code_t  seg_hex1,           // digit 1
   output sys_pkg::seg_code_t  seg_hex2,           // digit 2
   output sys_pkg::seg_code_t  seg_hex3,           // digit 3, bits 15:12
   output logic [7:0]          leds                // led bank
);
   import sys_pkg::*;

   typedef enum logic [1:0] {idle, rd_seg, rd_led} sc_state_t;

   sc_state_t state;                               // scan step
   logic      pend;                                // strobe seen mid scan

   always_ff @(posedge sys_clk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= idle;
         pend     <= 1'b0;
         sc_req   <= '0;
         seg_hex0 <= 8'hFF;                        // blank
         seg_hex1 <= 8'hFF;
         seg_hex2 <= 8'hFF;
         seg_hex3 <= 8'hFF;
         leds     <= 8'h00;
      end
      else if (sys_rst)
      begin
         state    <= idle;
         pend     <= 1'b0;
         sc_req   <= '0;
         seg_hex0 <= 8'hFF;
         seg_hex1 <= 8'hFF;
         seg_hex2 <= 8'hFF;
         seg_hex3 <= 8'hFF;
         leds     <= 8'h00;
      end
      else
      begin
         if (sys_us)
            pend <= 1'b1;
         case (state)
            idle:
               if (sys_us || pend)
               begin
                  pend       <= 1'b0;              // strobe consumed
                  sc_req.req <= 1'b1;
                  sc_req.we  <= 1'b0;
                  sc_req.adr <= 4'd0;              // digit register
                  state      <= rd_seg;
               end
            rd_seg:
               if (sc_rsp.ack)
               begin
                  seg_hex0   <= SEG_TABLE[sc_rsp.dat[3:0]];
                  seg_hex1   <= SEG_TABLE[sc_rsp.dat[7:4]];
                  seg_hex2   <= SEG_TABLE[sc_rsp.dat[11:8]];
                  seg_hex3   <= SEG_TABLE[sc_rsp.dat[15:12]];
                  sc_req.req <= 1'b0;              // one idle cycle between reads
                  sc_req.adr <= 4'd1;              // led register next
                  state      <= rd_led;
               end
            default:
               if (sc_rsp.ack)
               begin
                  leds       <= sc_rsp.dat[7:0];
                  sc_req.req <= 1'b0;
                  state      <= idle;
               end
               else
                  sc_req.req <= 1'b1;
         endcase
      end
   end

endmodule

//--- eg4_core.sv
module eg4_core
(
   input  logic               sys_clk_p,           // system clock
   input  logic               arst_n,              // async reset, active low
   input  logic               sys_plock,           // pll locked
   input  logic               ext_reset,           // reset button
   input  logic               uart_rxd,            // serial input
   output logic               sys_rst,             // system reset
   output logic               sys_us,              // microsecond strobe
   output sys_pkg::seg_code_t seg_hex0,            // seven segment digits
   output sys_pkg::seg_code_t seg_hex1,
   output sys_pkg::seg_code_t seg_hex2,
   output sys_pkg::seg_code_t seg_hex3,
   output logic [7:0]         leds                 // led bank
);
   import bus_pkg::*;

   logic     byte_stb;                             // receiver strobe
   byte_t    rx_byte;                              // receiver data
   logic     frame_err;                            // receiver framing error
   bus_req_t ld_req;                               // loader side
   bus_rsp_t ld_rsp;
   bus_req_t sc_req;                               // scanner side
   bus_rsp_t sc_rsp;
   bus_req_t mem_req;                              // register file side
   bus_rsp_t mem_rsp;

   sys_ctl i_sys_ctl (
      .sys_clk_p(sys_clk_p), .arst_n(arst_n),
      .sys_plock(sys_plock), .ext_reset(ext_reset),
      .sys_rst(sys_rst), .sys_us(sys_us)
   );

   uart_rx i_uart_rx (
      .sys_clk_p(sys_clk_p), .arst_n(arst_n), .sys_rst(sys_rst),
      .uart_rxd(uart_rxd), .byte_stb(byte_stb),
      .rx_byte(rx_byte), .frame_err(frame_err)
   );

   cmd_loader i_cmd_loader (
      .sys_clk_p(sys_clk_p), .arst_n(arst_n), .sys_rst(sys_rst),
      .byte_stb(byte_stb), .rx_byte(rx_byte), .frame_err(frame_err),
      .ld_rsp(ld_rsp), .ld_req(ld_req)
   );

   bus_arb i_bus_arb (
      .sys_clk_p(sys_clk_p), .arst_n(arst_n), .sys_rst(sys_rst),
      .ld_req(ld_req), .sc_req(sc_req), .mem_rsp(mem_rsp),
      .ld_rsp(ld_rsp), .sc_rsp(sc_rsp), .mem_req(mem_req)
   );

   reg_ram i_reg_ram (
      .sys_clk_p(sys_clk_p), .arst_n(arst_n), .sys_rst(sys_rst),
      .mem_req(mem_req), .mem_rsp(mem_rsp)
   );

   disp_scan i_disp_scan (
      .sys_clk_p(sys_clk_p), .arst_n(arst_n), .sys_rst(sys_rst),
      .sys_us(sys_us), .sc_rsp(sc_rsp), .sc_req(sc_req),
      .seg_hex0(seg_hex0), .seg_hex1(seg_hex1),
      .seg_hex2(seg_hex2), .seg_hex3(seg_hex3),
      .leds(leds)
   );

endmodule

//--- tb_eg4_core.sv
module tb_eg4_core;
   timeunit 1ns;
   timeprecision 100ps;
   import sys_pkg::*;
   import bus_pkg::*;

   localparam int NUM_FRAMES  = 45;                // 20 + 6 + 10 + 3 x 3
   localparam int WATCHDOG_NS = 2 * NUM_FRAMES * 30 * int'(CLK_PER_BIT) * 20 + 1_000_000;

   // own copy of the digit codes, gfedcba inverted
   localparam logic [7:0] SEG_REF [16] = '{
      8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
      8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
   };

   logic       sys_clk_p;
   logic       arst_n;
   logic       sys_plock;
   logic       ext_reset;
   logic       uart_rxd;
   logic       sys_rst;
   logic       sys_us;
   logic [7:0] seg_hex0;
   logic [7:0] seg_hex1;
   logic [7:0] seg_hex2;
   logic [7:0] seg_hex3;
   logic [7:0] leds;

   reg_dat_t model [16];                           // expected register contents
   integer   seed;                                 // random stream state
   int       pass_cnt;
   int       fail_cnt;
   int       i;
   reg_dat_t dat;
   reg_adr_t adr;

   eg4_core i_eg4_core (.*);

   initial
   begin
      sys_clk_p = 1'b0;
      forever #10 sys_clk_p = ~sys_clk_p;          // 50 MHz
   end

   task automatic check_val(input string name, input logic [39:0] exp_val,
                            input logic [39:0] act_val);
      if (exp_val !== act_val)
      begin
         $display("FAILED %s expected %h actual %h", name, exp_val, act_val);
         fail_cnt++;
      end
      else
      begin
         $display("passed %s", name);
         pass_cnt++;
      end
   endtask

   // 5 us covers the three scan periods of the write path
   task automatic check_display(input string name);
      logic [39:0] exp_val;
      repeat (5 * int'(CLK_PER_US)) @(negedge sys_clk_p);
      exp_val = {SEG_REF[model[0][15:12]], SEG_REF[model[0][11:8]],
                 SEG_REF[model[0][7:4]], SEG_REF[model[0][3:0]], model[1][7:0]};
      check_val(name, exp_val, {seg_hex3, seg_hex2, seg_hex1, seg_hex0, leds});
   endtask

   task automatic wait_rst(input logic level, input string what);
      int n;
      n = 0;
      do
      begin
         @(negedge sys_clk_p);
         if (sys_rst && sys_us)
         begin
            $display("sys_us pulsed while sys_rst was high");
            fail_cnt++;
         end
         n++;
      end
      while (sys_rst !== level && n < 1000);
      if (sys_rst !== level)
      begin
         $display("%s did not happen, sys_rst stuck for 1000 cycles", what);
         fail_cnt++;
      end
      else
      begin
         $display("passed %s", what);
         pass_cnt++;
      end
   endtask

   task automatic check_strobe();
      int n;
      int k;
      n = 0;
      while (!sys_us && n < 200)
      begin
         @(negedge sys_clk_p);
         n++;
      end
      if (!sys_us)
      begin
         $display("no sys_us pulse seen after reset release");
         fail_cnt++;
      end
      else
         for (k = 0; k < 3; k++)
         begin
            n = 0;
            do
            begin
               @(negedge sys_clk_p);
               n++;
            end
            while (!sys_us && n < 200);               // cycles to next strobe
            check_val($sformatf("strobe period %0d", k), 40'(CLK_PER_US), 40'(n));
         end
   endtask

   // 8N1, lsb first, one bit time per bit
   task automatic send_byte(input byte_t b, input logic stop_bit);
      logic [9:0] bits;
      int         n;
      bits = {stop_bit, b, 1'b0};
      @(posedge sys_clk_p);
      for (n = 0; n < 10; n++)
      begin
         uart_rxd <= bits[n];
         repeat (CLK_PER_BIT) @(posedge sys_clk_p);
      end
      if (!stop_bit)
      begin
         uart_rxd <= 1'b1;                         // back to idle line
         repeat (CLK_PER_BIT) @(posedge sys_clk_p);
      end
   endtask

   task automatic send_frame(input reg_adr_t a, input reg_dat_t d);
      send_byte({FRAME_MARK, a}, 1'b1);
      send_byte(d[15:8], 1'b1);
      send_byte(d[7:0], 1'b1);
      model[a] = d;                                // only valid frames land
   endtask

   task automatic rand_word(output reg_dat_t w);
      int r;
      r = $random(seed);
      w = r[15:0];
   endtask

   function automatic byte_t not_mark(input byte_t b);
      not_mark = (b[7:4] == FRAME_MARK) ? (b ^ 8'h10) : b;   // never a header
   endfunction

   initial
   begin
      arst_n    = 1'b0;
      sys_plock = 1'b0;
      ext_reset = 1'b0;
      uart_rxd  = 1'b1;
      seed      = 32'h3a2d_f2a8;
      pass_cnt  = 0;
      fail_cnt  = 0;
      model     = '{default: '0};
      repeat (10) @(posedge sys_clk_p);
      arst_n <= 1'b1;
      @(posedge sys_clk_p);
      sys_plock <= 1'b1;                           // pll locks after reset
      wait_rst(1'b0, "reset release");
      check_strobe();
      check_display("reset display");
      for (i = 0; i < 20; i++)
      begin
         rand_word(dat);
         send_frame(4'd0, dat);
         check_display($sformatf("display write %0d", i));
      end
      for (i = 0; i < 6; i++)
      begin
         rand_word(dat);
         send_frame(4'd1, dat);
         check_display($sformatf("led write %0d", i));
      end
      for (i = 0; i < 10; i++)
      begin
         rand_word(dat);
         adr = dat[3:0];
         if (adr < 4'd2)
            adr = adr + 4'd2;                      // keep off display regs
         rand_word(dat);
         send_frame(adr, dat);
         check_display($sformatf("hidden write %0d reg %0d", i, adr));
      end
      for (i = 0; i < 3; i++)
      begin
         rand_word(dat);
         send_byte(not_mark({dat[15:12], 4'h0}), 1'b1);   // wrong mark, digit register
         send_byte(not_mark(dat[7:0]), 1'b1);
         send_byte(not_mark(dat[11:4]), 1'b1);
         check_display($sformatf("bad header %0d", i));
         rand_word(dat);
         send_byte({FRAME_MARK, 4'd0}, 1'b1);
         send_byte(dat[15:8], 1'b1);
         send_byte(dat[7:0], 1'b0);                // stop bit 0 cuts the frame
         check_display($sformatf("cut frame %0d", i));
         rand_word(dat);
         send_frame(4'd0, dat);
         check_display($sformatf("frame after reject %0d", i));
      end
      @(posedge sys_clk_p);
      ext_reset <= 1'b1;
      repeat (4) @(posedge sys_clk_p);
      ext_reset <= 1'b0;
      wait_rst(1'b1, "ext reset assert");
      model = '{default: '0};                      // registers cleared too
      wait_rst(1'b0, "ext reset release");
      check_display("display after ext reset");
      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   // twice the serial time plus margin for the checks
   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the tests did not finish in time");
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- list.f
sys_pkg.sv
bus_pkg.sv
sys_ctl.sv
uart_rx.sv
cmd_loader.sv
bus_arb.sv
reg_ram.sv
disp_scan.sv
eg4_core.sv
tb_eg4_core.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then judge the log
verilator --binary --timing --top-module tb_eg4_core -f list.f -o tb_eg4_core \
   && ./obj_dir/tb_eg4_core > sim.log 2>&1 \
   || { echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "run FAILED"; exit 1; } || { echo "run ok"; exit 0; }
